// File: verilog/btac_settings.svh
`ifndef BTAC_SETTINGS_SVH
`define BTAC_SETTINGS_SVH

// Predictor table sizes, one word per entry.
`define BTB_DEPTH 16
`define BTB_INDEX_W $clog2(`BTB_DEPTH)
`define BTB_TAG_W (30 - `BTB_INDEX_W)

`define BHT_DEPTH 32
`define BHT_INDEX_W $clog2(`BHT_DEPTH)

// Fetch credits equal the depth of the pending queue in the resolve stage.
`define FETCH_CREDITS 4
`define DECODE_CREDITS 2

`define RESET_PC 32'h0000_0000

`endif

// File: verilog/btac_pkg.sv
`include "btac_settings.svh"

package btac_pkg;

  // Conditional branch layout.
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fields_t;

  // Jump and link layout.
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fields_t;

  typedef union packed {
    b_fields_t b_view;
    j_fields_t j_view;
  } instr_word_u;

  typedef struct packed {
    logic        taken;
    logic [31:0] target;
    logic [1:0]  counter;
  } prediction_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic        epoch;
  } fetch_req_t;

  typedef struct packed {
    logic        valid;
    instr_word_u word;
    logic        taken; // Branch outcome, supplied in place of execute.
  } imem_rsp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] word;
    logic        mispredict;
  } decode_pkt_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } redirect_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] target;
    logic        is_branch;
    logic        taken;
  } btac_update_t;

  typedef struct packed {
    logic                  valid;
    logic [`BTB_TAG_W-1:0] tag;
    logic                  is_jump;
    logic [31:0]           target;
  } btb_entry_t;

endpackage

// File: verilog/btb.sv
`timescale 1ns/1ps
`include "btac_settings.svh"

module btb import btac_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    write_en,
  input  logic [`BTB_INDEX_W-1:0] write_index,
  input  btb_entry_t              write_entry,
  input  logic [`BTB_INDEX_W-1:0] read_index,
  output btb_entry_t              read_entry
);

  btb_entry_t entries [`BTB_DEPTH];

  assign read_entry = entries[read_index]; // Lookup is combinational.

  // Only the valid bits are cleared, tags and targets keep their contents.
  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < `BTB_DEPTH; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else if (write_en) begin
      entries[write_index] <= write_entry;
    end
  end

endmodule

// File: verilog/bht.sv
`timescale 1ns/1ps
`include "btac_settings.svh"

module bht (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [`BHT_INDEX_W-1:0] read_index,
  output logic [1:0]              read_counter,
  input  logic                    update_en,
  input  logic [`BHT_INDEX_W-1:0] update_index,
  input  logic                    update_taken
);

  logic [1:0] counters [`BHT_DEPTH];
  logic [1:0] current;

  assign read_counter = counters[read_index];
  assign current = counters[update_index];

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < `BHT_DEPTH; i++) begin
        counters[i] <= 2'b01; // Weakly not taken.
      end
    end else if (update_en) begin
      if (update_taken && current != 2'b11) begin
        counters[update_index] <= current + 2'd1;
      end else if (!update_taken && current != 2'b00) begin
        counters[update_index] <= current - 2'd1;
      end
    end
  end

endmodule

// File: verilog/btac.sv
`timescale 1ns/1ps
`include "btac_settings.svh"

module btac import btac_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  logic [31:0]  lookup_pc,
  output prediction_t  prediction,
  input  btac_update_t update
);

  logic [`BTB_INDEX_W-1:0] lookup_index;
  logic [`BTB_INDEX_W-1:0] update_index;
  logic [`BHT_INDEX_W-1:0] lookup_counter_index;
  logic [`BHT_INDEX_W-1:0] update_counter_index;
  btb_entry_t              lookup_entry;
  btb_entry_t              new_entry;
  logic [1:0]              lookup_counter;
  logic                    hit;
  logic                    btb_write;
  logic                    bht_update;

  // Both tables are indexed by word address, bits 1 and 0 are always zero.
  assign lookup_index = lookup_pc[`BTB_INDEX_W+1:2];
  assign update_index = update.pc[`BTB_INDEX_W+1:2];
  assign lookup_counter_index = lookup_pc[`BHT_INDEX_W+1:2];
  assign update_counter_index = update.pc[`BHT_INDEX_W+1:2];

  assign hit = lookup_entry.valid && (lookup_entry.tag == lookup_pc[31:`BTB_INDEX_W+2]);

  // A jump always goes to its target, a branch follows its counter.
  always_comb begin
    prediction.taken = hit && (lookup_entry.is_jump || lookup_counter[1]);
    prediction.target = lookup_entry.target;
    prediction.counter = lookup_counter;
  end

  // Targets are only learned from taken instructions.
  assign btb_write = update.valid && update.taken;
  assign bht_update = update.valid && update.is_branch;

  always_comb begin
    new_entry.valid = 1'b1;
    new_entry.tag = update.pc[31:`BTB_INDEX_W+2];
    new_entry.is_jump = !update.is_branch;
    new_entry.target = update.target;
  end

  btb btb_i (
    .clock       (clock),
    .reset       (reset),
    .write_en    (btb_write),
    .write_index (update_index),
    .write_entry (new_entry),
    .read_index  (lookup_index),
    .read_entry  (lookup_entry)
  );

  bht bht_i (
    .clock        (clock),
    .reset        (reset),
    .read_index   (lookup_counter_index),
    .read_counter (lookup_counter),
    .update_en    (bht_update),
    .update_index (update_counter_index),
    .update_taken (update.taken)
  );

endmodule

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps
`include "btac_settings.svh"

module fetch_stage import btac_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  prediction_t prediction,
  output logic [31:0] lookup_pc,
  output fetch_req_t  fetch_req,
  output prediction_t pred_out,
  input  redirect_t   redirect,
  input  logic        fetch_credit
);

  localparam int CREDIT_W = $clog2(`FETCH_CREDITS + 1);

  logic [31:0]         pc;
  logic                epoch;
  logic                started;
  logic [CREDIT_W-1:0] credits;
  logic                issue;

  // The first request goes out in the cycle after reset is released.
  assign issue = started && (credits != '0);

  assign lookup_pc = pc;
  assign pred_out = prediction; // Travels with the request into the pending queue.

  always_comb begin
    fetch_req.valid = issue;
    fetch_req.pc = pc;
    fetch_req.epoch = epoch;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      pc <= `RESET_PC;
      epoch <= 1'b0;
      started <= 1'b0;
      credits <= CREDIT_W'(`FETCH_CREDITS);
    end else begin
      started <= 1'b1;
      credits <= credits + CREDIT_W'(fetch_credit) - CREDIT_W'(issue);
      // A redirect wins over the prediction and opens a new epoch.
      if (redirect.valid) begin
        pc <= redirect.pc;
        epoch <= ~epoch;
      end else if (issue) begin
        pc <= prediction.taken ? prediction.target : pc + 32'd4;
      end
    end
  end

endmodule

// File: verilog/branch_resolve.sv
`timescale 1ns/1ps
`include "btac_settings.svh"

module branch_resolve import btac_pkg::*; (
  input  logic         clock,
  input  logic         reset,
  input  fetch_req_t   fetch_req,
  input  prediction_t  pred_in,
  input  logic         fetch_epoch,
  input  imem_rsp_t    imem_rsp,
  output logic         fetch_credit,
  output redirect_t    redirect,
  output btac_update_t update,
  output decode_pkt_t  decode_pkt,
  input  logic         decode_credit
);

  localparam int PTR_W = $clog2(`FETCH_CREDITS);
  localparam int COUNT_W = $clog2(`FETCH_CREDITS + 1);
  localparam int DCREDIT_W = $clog2(`DECODE_CREDITS + 1);
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL = 7'b1101111;

  typedef struct packed {
    logic [31:0] pc;
    prediction_t pred;
    logic        epoch;
    instr_word_u word;
    logic        taken;
  } pending_t;

  fetch_req_t           req_q;
  prediction_t          pred_q;
  pending_t             queue [`FETCH_CREDITS];
  pending_t             head;
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [COUNT_W-1:0]   count;
  logic [DCREDIT_W-1:0] decode_credits;
  logic                 push;
  logic                 pop;
  logic                 send;
  logic                 stale;
  logic                 is_branch;
  logic                 is_jal;
  logic                 taken;
  logic                 mispredict;
  logic [31:0]          b_imm;
  logic [31:0]          j_imm;
  logic [31:0]          seq_pc;
  logic [31:0]          taken_pc;
  logic [31:0]          actual_pc;
  logic [31:0]          predicted_pc;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`FETCH_CREDITS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // The response lands one cycle after its request.
  assign push = req_q.valid && imem_rsp.valid;

  assign head = queue[rd_ptr];
  assign stale = head.epoch != fetch_epoch;
  assign pop = (count != '0) && (stale || decode_credits != '0);
  assign send = (count != '0) && !stale && (decode_credits != '0);

  // The same word is read through both immediate layouts.
  assign is_branch = head.word.b_view.opcode == OP_BRANCH;
  assign is_jal = head.word.j_view.opcode == OP_JAL;
  assign b_imm = {{20{head.word.b_view.imm_12}}, head.word.b_view.imm_11,
                  head.word.b_view.imm_10_5, head.word.b_view.imm_4_1, 1'b0};
  assign j_imm = {{12{head.word.j_view.imm_20}}, head.word.j_view.imm_19_12,
                  head.word.j_view.imm_11, head.word.j_view.imm_10_1, 1'b0};

  assign seq_pc = head.pc + 32'd4;
  assign taken_pc = head.pc + (is_jal ? j_imm : b_imm);
  assign taken = is_jal || (is_branch && head.taken);
  assign actual_pc = taken ? taken_pc : seq_pc;
  assign predicted_pc = head.pred.taken ? head.pred.target : seq_pc;
  assign mispredict = actual_pc != predicted_pc;

  assign fetch_credit = pop; // Dropped entries give their slot back as well.

  always_comb begin
    decode_pkt.valid = send;
    decode_pkt.pc = head.pc;
    decode_pkt.word = head.word;
    decode_pkt.mispredict = mispredict;
    redirect.valid = send && mispredict;
    redirect.pc = actual_pc;
    update.valid = send && (is_branch || is_jal);
    update.pc = head.pc;
    update.target = taken_pc;
    update.is_branch = is_branch;
    update.taken = taken;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      req_q <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      decode_credits <= DCREDIT_W'(`DECODE_CREDITS);
    end else begin
      req_q <= fetch_req;
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + COUNT_W'(push) - COUNT_W'(pop);
      decode_credits <= decode_credits + DCREDIT_W'(decode_credit) - DCREDIT_W'(send);
    end
  end

  always_ff @(posedge clock) begin
    pred_q <= pred_in;
    if (push) begin
      queue[wr_ptr] <= '{pc: req_q.pc, pred: pred_q, epoch: req_q.epoch,
                         word: imem_rsp.word, taken: imem_rsp.taken};
    end
  end

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import btac_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  output fetch_req_t  fetch_req,
  input  imem_rsp_t   imem_rsp,
  output decode_pkt_t decode_pkt,
  input  logic        decode_credit
);

  logic [31:0]  lookup_pc;
  prediction_t  prediction;
  prediction_t  fetch_pred;
  redirect_t    redirect;
  btac_update_t update;
  logic         fetch_credit;

  btac btac_i (
    .clock      (clock),
    .reset      (reset),
    .lookup_pc  (lookup_pc),
    .prediction (prediction),
    .update     (update)
  );

  fetch_stage fetch_stage_i (
    .clock        (clock),
    .reset        (reset),
    .prediction   (prediction),
    .lookup_pc    (lookup_pc),
    .fetch_req    (fetch_req),
    .pred_out     (fetch_pred),
    .redirect     (redirect),
    .fetch_credit (fetch_credit)
  );

  // The epoch of the current request tells the resolve stage which entries are stale.
  branch_resolve branch_resolve_i (
    .clock         (clock),
    .reset         (reset),
    .fetch_req     (fetch_req),
    .pred_in       (fetch_pred),
    .fetch_epoch   (fetch_req.epoch),
    .imem_rsp      (imem_rsp),
    .fetch_credit  (fetch_credit),
    .redirect      (redirect),
    .update        (update),
    .decode_pkt    (decode_pkt),
    .decode_credit (decode_credit)
  );

endmodule

// File: verification/fetch_unit_asserts.sv
`timescale 1ns/1ps
`include "btac_settings.svh"

module fetch_unit_asserts (
  input logic clock,
  input logic reset,
  input logic decode_valid,
  input logic decode_credit,
  input logic redirect_valid,
  input logic req_valid,
  input logic req_epoch,
  input logic fetch_epoch
);

  int available; // Credits that decode has granted and not yet seen used.

  always_ff @(posedge clock) begin
    if (!reset) begin
      available <= `DECODE_CREDITS;
    end else begin
      available <= available + int'(decode_credit) - int'(decode_valid);
    end
  end

  // Decode must have granted a slot for every packet it receives.
  send_needs_credit: assert property (@(posedge clock) disable iff (!reset)
    decode_valid |-> available > 0)
    else $error("Decode packet sent with no decode credit left");

  // After a redirect only the new epoch may be fetched.
  redirect_flips_epoch: assert property (@(posedge clock) disable iff (!reset)
    redirect_valid |=> !req_valid || req_epoch != $past(fetch_epoch))
    else $error("Request after a redirect still carries the old epoch");

endmodule

bind branch_resolve fetch_unit_asserts asserts_i (
  .clock          (clock),
  .reset          (reset),
  .decode_valid   (decode_pkt.valid),
  .decode_credit  (decode_credit),
  .redirect_valid (redirect.valid),
  .req_valid      (fetch_req.valid),
  .req_epoch      (fetch_req.epoch),
  .fetch_epoch    (fetch_epoch)
);

// File: verification/fetch_unit_tb.sv
`timescale 1ns/1ps
`include "btac_settings.svh"

module fetch_unit_tb import btac_pkg::*; ();

  localparam int LOOP_COUNT = 6;
  localparam int LOOP_LENGTH = 8;
  localparam int EXIT_LENGTH = 4;
  localparam int EXPECTED_COUNT = LOOP_COUNT * LOOP_LENGTH + EXIT_LENGTH;
  localparam int CYCLE_LIMIT = 20 * EXPECTED_COUNT;
  localparam int PROG_LENGTH = 13;
  localparam logic [31:0] BRANCH_PC = 32'h0000_0020;
  localparam logic [31:0] NOP = 32'h0000_0013;

  typedef enum logic [1:0] {PLAIN, BRANCH, JAL} kind_e;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
    kind_e       kind;
    logic [31:0] target;
    logic        taken; // Outcome inside the loop.
  } row_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] word;
    logic        mispredict;
  } expect_t;

  logic        clock;
  logic        reset;
  fetch_req_t  fetch_req;
  imem_rsp_t   imem_rsp;
  decode_pkt_t decode_pkt;
  logic        decode_credit;

  row_t        prog [PROG_LENGTH];
  expect_t     expected [$];
  fetch_req_t  last_req;
  int          errors;
  int          received;
  int          held;
  int          cycles;
  int          branch_fetches;
  int          seed;
  logic        seen_request;
  logic        expected_epoch;

  fetch_unit fetch_unit_i (
    .clock         (clock),
    .reset         (reset),
    .fetch_req     (fetch_req),
    .imem_rsp      (imem_rsp),
    .decode_pkt    (decode_pkt),
    .decode_credit (decode_credit)
  );

  always #20 clock = ~clock;

  function automatic logic [31:0] alu_word(input int n);
    return {12'(n), 5'd0, 3'b000, 5'(n), 7'h13}; // addi xn, x0, n
  endfunction

  function automatic logic [31:0] jal_word(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
  endfunction

  function automatic logic [31:0] beq_word(input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] memory_word(input logic [31:0] pc);
    int idx;
    idx = int'(pc[31:2]);
    if (idx < PROG_LENGTH) begin
      return prog[idx].word;
    end
    return NOP; // Past the exit code the program runs into no-ops.
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] want);
    if (actual !== want) begin
      $display("Mismatch %s: got %h, expected %h", name, actual, want);
      errors++;
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < PROG_LENGTH; i++) begin
      prog[i] = '{pc: 32'(i * 4), word: alu_word(i + 1), kind: PLAIN,
                  target: 32'(i * 4 + 4), taken: 1'b0};
    end
    // The jal skips the word at 0x10 and the beq closes the loop back to 0.
    prog[3] = '{pc: 32'h0c, word: jal_word(21'd8), kind: JAL, target: 32'h14, taken: 1'b1};
    prog[8] = '{pc: BRANCH_PC, word: beq_word(13'h1fe0), kind: BRANCH,
                target: 32'h00, taken: 1'b1};
  endtask

  // Walks the architectural path and predicts with a per-pc BTB and counter.
  task automatic build_expected();
    logic        btb_valid [PROG_LENGTH];
    logic        btb_jump [PROG_LENGTH];
    logic [31:0] btb_target [PROG_LENGTH];
    logic [1:0]  counter [PROG_LENGTH];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] predicted;
    logic        taken;
    int          idx;
    int          iteration;
    expect_t     entry;
    pc = `RESET_PC;
    iteration = 0;
    for (int i = 0; i < PROG_LENGTH; i++) begin
      btb_valid[i] = 1'b0;
      btb_jump[i] = 1'b0;
      btb_target[i] = '0;
      counter[i] = 2'd1;
    end
    while (expected.size() < EXPECTED_COUNT) begin
      idx = int'(pc[31:2]);
      taken = prog[idx].taken;
      if (prog[idx].kind == BRANCH) begin
        iteration++;
        taken = taken && (iteration < LOOP_COUNT); // The last pass falls through.
      end
      next_pc = taken ? prog[idx].target : pc + 32'd4;
      predicted = pc + 32'd4;
      if (btb_valid[idx] && (btb_jump[idx] || counter[idx] >= 2'd2)) begin
        predicted = btb_target[idx];
      end
      entry.pc = pc;
      entry.word = prog[idx].word;
      entry.mispredict = next_pc != predicted;
      expected.push_back(entry);
      if (taken) begin
        btb_valid[idx] = 1'b1;
        btb_jump[idx] = prog[idx].kind == JAL;
        btb_target[idx] = next_pc;
      end
      if (prog[idx].kind == BRANCH) begin
        if (taken && counter[idx] != 2'd3) begin
          counter[idx] = counter[idx] + 2'd1;
        end else if (!taken && counter[idx] != 2'd0) begin
          counter[idx] = counter[idx] - 2'd1;
        end
      end
      pc = next_pc;
    end
  endtask

  task automatic drive_memory();
    imem_rsp.valid = last_req.valid;
    imem_rsp.word = memory_word(last_req.pc);
    imem_rsp.taken = 1'b0;
    // Wrong paths are at most three words long, so every branch fetch is a real one.
    if (last_req.valid && last_req.pc == BRANCH_PC) begin
      branch_fetches++;
      imem_rsp.taken = branch_fetches < LOOP_COUNT;
    end
    if (fetch_req.valid && !seen_request) begin
      check_value("fetch_req.pc", fetch_req.pc, `RESET_PC);
      seen_request = 1'b1;
    end
    if (fetch_req.valid) begin
      check_value("fetch_req.epoch", 32'(fetch_req.epoch), 32'(expected_epoch));
    end
    last_req = fetch_req;
  endtask

  task automatic drive_decode();
    int r;
    r = $random(seed);
    decode_credit = 1'b0;
    // One block of 16 cycles in every 64 returns no credits at all.
    if (held > 0 && (cycles / 16) % 4 != 3 && r[0]) begin
      decode_credit = 1'b1;
      held--;
    end
    if (decode_pkt.valid) begin
      if (!seen_request) begin
        $display("Decode packet appeared before the first fetch request");
        errors++;
      end
      held++;
      if (held > `DECODE_CREDITS) begin
        $display("Decode holds %0d packets, more than its %0d credits", held, `DECODE_CREDITS);
        errors++;
      end
      check_value("decode_pkt.pc", decode_pkt.pc, expected[received].pc);
      check_value("decode_pkt.word", decode_pkt.word, expected[received].word);
      check_value("decode_pkt.mispredict", 32'(decode_pkt.mispredict),
                  32'(expected[received].mispredict));
      if (expected[received].mispredict) begin
        expected_epoch = ~expected_epoch; // Fetch restarts in a new epoch after a redirect.
      end
      received++;
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b0;
    imem_rsp = '0;
    decode_credit = 1'b0;
    last_req = '0;
    errors = 0;
    received = 0;
    held = 0;
    cycles = 0;
    branch_fetches = 0;
    seed = 10;
    seen_request = 1'b0;
    expected_epoch = 1'b0;
    load_program();
    build_expected();
    repeat (2) begin
      @(negedge clock);
      check_value("fetch_req.valid", 32'(fetch_req.valid), 32'd0);
      check_value("decode_pkt.valid", 32'(decode_pkt.valid), 32'd0);
    end
    reset = 1'b1;
    while (received < EXPECTED_COUNT && cycles < CYCLE_LIMIT) begin
      drive_memory();
      drive_decode();
      @(negedge clock);
      cycles++;
    end
    if (received < EXPECTED_COUNT) begin
      $display("Timeout after %0d cycles with only %0d of %0d packets decoded",
               cycles, received, EXPECTED_COUNT);
      errors++;
    end
    $display("Errors: %0d, packets checked: %0d of %0d", errors, received, EXPECTED_COUNT);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+verilog
verilog/btac_pkg.sv
verilog/btb.sv
verilog/bht.sv
verilog/btac.sv
verilog/fetch_stage.sv
verilog/branch_resolve.sv
verilog/fetch_unit.sv
verification/fetch_unit_asserts.sv
verification/fetch_unit_tb.sv

// File: run_sim.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module fetch_unit_tb \
  -f verilog.f -o fetch_unit_sim > build.log 2>&1 \
  && ./obj_dir/fetch_unit_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation stopped with an error"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0
